//--- ctrl_bus_pkg.sv
/*
 * Bus-level types and the address map shared by the fabric, its slaves and the
 * testbench. Modules pull it in with a wildcard import in their header.
 */

package ctrl_bus_pkg;

   // Bus widths
   typedef logic [31:0] wb_data_t;
   typedef logic [15:0] wb_addr_t;

   // Upper address bits used for slave selection
   localparam int DECODE_W = 8;

   // Settings window, 8K..12K
   localparam logic [DECODE_W-1:0] SETTINGS_BASE = 8'h20;
   localparam logic [DECODE_W-1:0] SETTINGS_MASK = 8'hF0;

   // Readback words, a single 256 byte page
   localparam logic [DECODE_W-1:0] READBACK_BASE = 8'h33;
   localparam logic [DECODE_W-1:0] READBACK_MASK = 8'hFF;

   // Master to slave, held stable until ack or err
   typedef struct packed {
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   // Slave to master, one cycle wide
   typedef struct packed {
      logic     ack;
      logic     err;
      wb_data_t dat;
   } wb_rsp_t;

endpackage

//--- ctrl_regs_pkg.sv
/*
 * Settings-bus types, setting register map and readback word indices.
 * Shared by the register bank, the timer, the readback slave and the testbench.
 */

package ctrl_regs_pkg;

   import ctrl_bus_pkg::*;

   typedef logic [7:0] set_addr_t;
   typedef logic [7:0] led_t;

   // One-cycle strobed word from the settings bus
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      wb_data_t  data;
   } set_bus_t;

   // Board control lines, MSB first in setting register bit order
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset;
   } ctrl_outs_t;

   // Setting register addresses
   localparam set_addr_t SR_CLK      = 8'd0;
   localparam set_addr_t SR_SER      = 8'd1;
   localparam set_addr_t SR_ADC      = 8'd2;
   localparam set_addr_t SR_LED      = 8'd3;
   localparam set_addr_t SR_PHY      = 8'd4;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   localparam set_addr_t SR_SIMTIMER = 8'd198;  // uses 2 regs

   // Readback word indices
   localparam int unsigned RB_CONFIG = 9;
   localparam int unsigned RB_IRQ    = 13;
   localparam int unsigned RB_CYCLES = 15;

endpackage

//--- wb_decoder.sv
/*
 * Single-master address decoder. Steers strobes to the settings or readback slave,
 * merges their responses and answers unmapped accesses with err.
 */
`timescale 1ns/1ps

module wb_decoder import ctrl_bus_pkg::*; (
   input  logic    dsp_clk,
   input  logic    wb_rst,
   input  wb_req_t m_req_i,
   output wb_rsp_t m_rsp_o,
   output wb_req_t set_req_o,
   input  wb_rsp_t set_rsp_i,
   output wb_req_t rb_req_o,
   input  wb_rsp_t rb_rsp_i
);

   logic [DECODE_W-1:0] dec_field;
   logic                set_hit;
   logic                rb_hit;
   logic                err_q;

   assign dec_field = m_req_i.adr[$bits(wb_addr_t)-1 -: DECODE_W];
   assign set_hit   = (dec_field & SETTINGS_MASK) == SETTINGS_BASE;
   assign rb_hit    = (dec_field & READBACK_MASK) == READBACK_BASE;

   // Only the selected slave sees the strobe
   always_comb begin
      set_req_o     = m_req_i;
      set_req_o.stb = m_req_i.stb & set_hit;
      rb_req_o      = m_req_i;
      rb_req_o.stb  = m_req_i.stb & rb_hit;
   end

   // Nobody home, answer with err one cycle later
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= m_req_i.stb & ~set_hit & ~rb_hit & ~err_q;
      end
   end

   always_comb begin
      m_rsp_o.ack = set_rsp_i.ack | rb_rsp_i.ack;
      m_rsp_o.err = err_q | set_rsp_i.err | rb_rsp_i.err;
      if (rb_rsp_i.ack) begin
         m_rsp_o.dat = rb_rsp_i.dat;
      end else if (set_rsp_i.ack) begin
         m_rsp_o.dat = set_rsp_i.dat;
      end else begin
         m_rsp_o.dat = '0;
      end
   end

endmodule

//--- settings_bus.sv
/*
 * Turns bus writes in the settings window into one-cycle address/data strobes.
 * Reads are acked with zero data.
 */
`timescale 1ns/1ps

module settings_bus import ctrl_bus_pkg::*, ctrl_regs_pkg::*; (
   input  logic     dsp_clk,
   input  logic     wb_rst,
   input  wb_req_t  req_i,
   output wb_rsp_t  rsp_o,
   output set_bus_t set_o
);

   logic      new_req;
   logic      ack_q;
   logic      set_stb_q;
   set_addr_t set_addr_q;
   wb_data_t  set_data_q;

   // Strobe stays up through the ack cycle, so ignore it once acked
   assign new_req = req_i.stb & ~ack_q;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= new_req;
         set_stb_q <= new_req & req_i.we;
      end
   end

   // Word address from byte address
   always_ff @(posedge dsp_clk) begin
      if (new_req) begin
         set_addr_q <= req_i.adr[9:2];
         set_data_q <= req_i.dat;
      end
   end

   assign rsp_o.ack  = ack_q;
   assign rsp_o.err  = 1'b0;
   assign rsp_o.dat  = '0;
   assign set_o.stb  = set_stb_q;
   assign set_o.addr = set_addr_q;
   assign set_o.data = set_data_q;

endmodule

//--- setting_bank.sv
/*
 * Setting registers for clock generator, SERDES, ADC, PHY reset and LEDs.
 * Each loads on a settings strobe at its own address.
 */
`timescale 1ns/1ps

module setting_bank import ctrl_regs_pkg::*; (
   input  logic       dsp_clk,
   input  logic       wb_rst,
   input  set_bus_t   set_i,
   input  logic       clk_status_i,
   input  logic       link_up_i,
   output ctrl_outs_t ctrl_o,
   output led_t       leds_o
);

   logic [4:0] clk_q;
   logic [3:0] ser_q;
   logic [3:0] adc_q;
   logic       phy_q;
   led_t       led_sw_q;
   led_t       led_src_q;
   led_t       led_hw;

   //////////////////////////////
   // Register file

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_q     <= '0;
         ser_q     <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= '0;
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_CLK:     clk_q     <= set_i.data[4:0];
            SR_SER:     ser_q     <= set_i.data[3:0];
            SR_ADC:     adc_q     <= set_i.data[3:0];
            SR_LED:     led_sw_q  <= set_i.data[7:0];
            SR_PHY:     phy_q     <= set_i.data[0];
            SR_LED_SRC: led_src_q <= set_i.data[7:0];
            default:    ;
         endcase
      end
   end

   // Field order of ctrl_outs_t matches the register bits
   assign ctrl_o = {clk_q, ser_q, adc_q, phy_q};

   //////////////////////////////
   // LEDs

   // Hardware sources, upper LEDs have none
   assign led_hw = {6'b0, clk_status_i, link_up_i};

   // Source bit set means hardware drives the LED
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

//--- simple_timer.sv
/*
 * One-shot and periodic interrupt timers loaded over the settings bus.
 * BASE sets the one-shot count, BASE+1 the period; zero stops either.
 */
`timescale 1ns/1ps

module simple_timer import ctrl_regs_pkg::*; #(
   parameter int unsigned BASE  = 0,
   parameter int unsigned CNT_W = 32
) (
   input  logic     dsp_clk,
   input  logic     wb_rst,
   input  set_bus_t set_i,
   output logic     onetime_int_o,
   output logic     periodic_int_o
);

   logic [CNT_W-1:0] set_val;
   logic             onetime_wr;
   logic             period_wr;
   logic [CNT_W-1:0] onetime_cnt;
   logic [CNT_W-1:0] period_q;
   logic [CNT_W-1:0] periodic_cnt;

   assign set_val    = set_i.data[CNT_W-1:0];
   assign onetime_wr = set_i.stb && (set_i.addr == set_addr_t'(BASE));
   assign period_wr  = set_i.stb && (set_i.addr == set_addr_t'(BASE + 1));

   // One-shot, counts down to 1 then parks at 0
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         onetime_cnt <= '0;
      end else if (onetime_wr) begin
         onetime_cnt <= set_val;
      end else if (onetime_cnt != '0) begin
         onetime_cnt <= onetime_cnt - 1'b1;
      end
   end

   // Periodic, reloads from the held period on each tick
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period_q     <= '0;
         periodic_cnt <= '0;
      end else if (period_wr) begin
         period_q     <= set_val;
         periodic_cnt <= set_val;
      end else if (periodic_cnt == CNT_W'(1)) begin
         periodic_cnt <= period_q;
      end else if (periodic_cnt != '0) begin
         periodic_cnt <= periodic_cnt - 1'b1;
      end
   end

   // Count of 1 lands N cycles after the load strobe
   assign onetime_int_o  = (onetime_cnt == CNT_W'(1));
   assign periodic_int_o = (periodic_cnt == CNT_W'(1));

endmodule

//--- readback_mux.sv
/*
 * Readback slave returning the config, irq and cycle-count words.
 * Writes are acked and dropped.
 */
`timescale 1ns/1ps

module readback_mux import ctrl_bus_pkg::*, ctrl_regs_pkg::*; (
   input  logic     dsp_clk,
   input  logic     wb_rst,
   input  wb_req_t  req_i,
   output wb_rsp_t  rsp_o,
   input  wb_data_t config_word_i,
   input  wb_data_t irq_word_i
);

   logic [3:0] rb_idx;
   logic       new_req;
   logic       ack_q;
   wb_data_t   cycle_cnt;
   wb_data_t   rd_word;
   wb_data_t   dat_q;

   assign rb_idx  = req_i.adr[5:2];
   assign new_req = req_i.stb & ~ack_q;

   // Free-running since reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
         ack_q     <= 1'b0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;
         ack_q     <= new_req;
      end
   end

   always_comb begin
      case (rb_idx)
         4'(RB_CONFIG): rd_word = config_word_i;
         4'(RB_IRQ):    rd_word = irq_word_i;
         4'(RB_CYCLES): rd_word = cycle_cnt;
         default:       rd_word = '0;
      endcase
   end

   // Captured on the edge that raises ack
   always_ff @(posedge dsp_clk) begin
      if (new_req) begin
         dat_q <= rd_word;
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.dat = dat_q;

endmodule

//--- ctrl_core.sv
/*
 * Control-plane top level. Bus fabric, settings bus, register bank, timer and
 * readback slave, wired to the board control pins.
 */
`timescale 1ns/1ps

module ctrl_core import ctrl_bus_pkg::*, ctrl_regs_pkg::*; (
   input  logic       dsp_clk,
   input  logic       wb_rst,
   input  wb_req_t    bus_req_i,
   output wb_rsp_t    bus_rsp_o,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i,
   input  logic       button_i,
   input  logic       clk_status_i,
   input  logic       link_up_i,
   input  logic       phy_int_n_i,
   output ctrl_outs_t ctrl_o,
   output logic       phy_reset_n_o,
   output led_t       leds_o,
   output logic       onetime_int_o,
   output logic       periodic_int_o
);

   localparam int unsigned TIMER_W = 32;

   wb_req_t  set_req;
   wb_rsp_t  set_rsp;
   wb_req_t  rb_req;
   wb_rsp_t  rb_rsp;
   set_bus_t set_bus;
   wb_data_t config_word;
   wb_data_t irq_word;

   //////////////////////////////
   // Fabric and settings

   wb_decoder wb_decoder_inst (
      .dsp_clk, .wb_rst,
      .m_req_i(bus_req_i), .m_rsp_o(bus_rsp_o),
      .set_req_o(set_req), .set_rsp_i(set_rsp),
      .rb_req_o(rb_req), .rb_rsp_i(rb_rsp));

   settings_bus settings_bus_inst (
      .dsp_clk, .wb_rst, .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus));

   setting_bank setting_bank_inst (
      .dsp_clk, .wb_rst, .set_i(set_bus),
      .clk_status_i, .link_up_i, .ctrl_o, .leds_o);

   // PHY reset pin is active low
   assign phy_reset_n_o = ~ctrl_o.phy_reset;

   simple_timer #(.BASE(SR_SIMTIMER), .CNT_W(TIMER_W)) simple_timer_inst (
      .dsp_clk, .wb_rst, .set_i(set_bus), .onetime_int_o, .periodic_int_o);

   //////////////////////////////
   // Readback

   assign config_word = {sim_mode_i, 27'b0, clock_divider_i};
   assign irq_word    = {18'b0, button_i, periodic_int_o, clk_status_i, link_up_i,
                         5'b0, phy_int_n_i, 4'b0};

   readback_mux readback_mux_inst (
      .dsp_clk, .wb_rst, .req_i(rb_req), .rsp_o(rb_rsp),
      .config_word_i(config_word), .irq_word_i(irq_word));

endmodule

//--- ctrl_core_properties.sv
/*
 * Bus and settings-strobe rules, bound into the control-plane top level.
 */
`timescale 1ns/1ps

module ctrl_core_properties import ctrl_bus_pkg::*, ctrl_regs_pkg::*; (
   input logic     dsp_clk,
   input logic     wb_rst,
   input wb_req_t  bus_req_i,
   input wb_rsp_t  bus_rsp_i,
   input set_bus_t set_i
);

   //////////////////////////////
   // Response rules

   ack_err_excl: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !(bus_rsp_i.ack && bus_rsp_i.err))
      else $error("ack and err high in the same cycle");

   ack_one_cycle: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      bus_rsp_i.ack |=> !bus_rsp_i.ack)
      else $error("ack held longer than one cycle");

   err_one_cycle: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      bus_rsp_i.err |=> !bus_rsp_i.err)
      else $error("err held longer than one cycle");

   //////////////////////////////
   // Settings strobe only with a write ack

   set_stb_on_write: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_i.stb |-> (bus_rsp_i.ack && bus_req_i.we))
      else $error("settings strobe without a write ack");

endmodule

//--- ctrl_core_tb.sv
/*
 * Testbench for the control-plane core. Acts as the bus master, applies a table
 * of writes, reads, timer and unmapped accesses, and checks the board pins.
 */
`timescale 1ns/1ps

module ctrl_core_tb import ctrl_bus_pkg::*, ctrl_regs_pkg::*; ();

   localparam logic [2:0] K_WR = 0, K_LED = 1, K_RD = 2, K_CYC = 3;
   localparam logic [2:0] K_ONE = 4, K_PER = 5, K_ERR = 6;
   localparam int NROWS = 20;
   localparam int MAX_TMR = 20;
   // Bus rows take a few cycles and timer rows about 5 periods each
   localparam int CYC_LIMIT = 60 + NROWS * 12 + 2 * (6 * MAX_TMR + 20);

   typedef struct packed {
      logic [2:0] kind;
      wb_addr_t   addr;
      wb_data_t   data;
      wb_data_t   exp;
   } op_t;

   logic dsp_clk = 1'b0;
   logic wb_rst;
   wb_req_t bus_req;
   wb_rsp_t bus_rsp;
   logic sim_mode, button, clk_status, link_up, phy_int_n;
   logic [3:0] clock_divider;
   ctrl_outs_t ctrl;
   logic phy_reset_n, onetime_int, periodic_int;
   led_t leds;

   op_t op_tbl [NROWS];
   int cyc = 0;
   int ack_cyc;
   int errors = 0;
   int checks = 0;
   logic row_fail;
   int one_q[$];
   int per_q[$];

   ctrl_core ctrl_core_inst (
      .dsp_clk, .wb_rst, .bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
      .sim_mode_i(sim_mode), .clock_divider_i(clock_divider), .button_i(button),
      .clk_status_i(clk_status), .link_up_i(link_up), .phy_int_n_i(phy_int_n),
      .ctrl_o(ctrl), .phy_reset_n_o(phy_reset_n), .leds_o(leds),
      .onetime_int_o(onetime_int), .periodic_int_o(periodic_int));

   bind ctrl_core ctrl_core_properties ctrl_core_properties_inst (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .bus_req_i(bus_req_i),
      .bus_rsp_i(bus_rsp_o), .set_i(set_bus));

   always #4 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYC_LIMIT) begin
         $display("timeout: run went past %0d cycles", CYC_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Interrupt pulse time stamps
   always @(negedge dsp_clk) begin
      if (onetime_int) begin
         one_q.push_back(cyc);
      end
      if (periodic_int) begin
         per_q.push_back(cyc);
      end
   end

   task automatic check_val(input string name, input wb_data_t got, input wb_data_t exp);
      checks++;
      assert (got === exp) else begin
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
         errors++;
         row_fail = 1'b1;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("error at %0t: %s", $time, what);
         errors++;
         row_fail = 1'b1;
      end
   endtask

   // One bus cycle that returns at the falling edge after the response
   task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output logic got_ack, output logic got_err,
                             output wb_data_t rdat, output int waited);
      bus_req = '{stb: 1'b1, we: we, adr: adr, dat: wdat};
      waited = 0;
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (!(bus_rsp.ack || bus_rsp.err) && waited < 8);
      got_ack = bus_rsp.ack;
      got_err = bus_rsp.err;
      rdat = bus_rsp.dat;
      ack_cyc = cyc;
      bus_req.stb = 1'b0;
      @(negedge dsp_clk);
   endtask

   function automatic wb_addr_t set_adr(input int unsigned r);
      return 16'h2000 | wb_addr_t'(r << 2);
   endfunction

   function automatic wb_addr_t rb_adr(input int unsigned idx);
      return 16'h3300 | wb_addr_t'(idx << 2);
   endfunction

   // Each LED takes the hardware input where its source bit is set
   function automatic led_t expected_leds(input led_t src, input led_t sw,
                                          input logic clk_st, input logic link);
      led_t res;
      logic hw;
      for (int b = 0; b < 8; b++) begin
         if (b == 0) begin
            hw = link;
         end else if (b == 1) begin
            hw = clk_st;
         end else begin
            hw = 1'b0;
         end
         res[b] = src[b] ? hw : sw[b];
      end
      return res;
   endfunction

   // Expected values follow a model of the register map
   task automatic build_table();
      logic [4:0] m_clk;
      logic [3:0] m_ser, m_adc;
      logic m_phy;
      led_t m_led, m_src;
      wb_data_t d;
      m_clk = 5'($urandom);
      m_ser = 4'($urandom);
      m_adc = 4'($urandom);
      m_phy = 1'($urandom);
      m_led = 8'($urandom);
      m_src = 8'($urandom);
      op_tbl[0] = '{K_WR, set_adr(SR_CLK), {27'($urandom), m_clk}, {18'b0, m_clk, 9'b0}};
      op_tbl[1] = '{K_WR, set_adr(SR_SER), {28'($urandom), m_ser},
                    {18'b0, m_clk, m_ser, 5'b0}};
      op_tbl[2] = '{K_WR, set_adr(SR_ADC), {28'($urandom), m_adc},
                    {18'b0, m_clk, m_ser, m_adc, 1'b0}};
      op_tbl[3] = '{K_WR, set_adr(SR_PHY), {31'($urandom), ~m_phy},
                    {18'b0, m_clk, m_ser, m_adc, ~m_phy}};
      op_tbl[4] = '{K_WR, set_adr(5), $urandom, {18'b0, m_clk, m_ser, m_adc, ~m_phy}};
      op_tbl[5] = '{K_WR, set_adr(SR_PHY), {31'($urandom), m_phy},
                    {18'b0, m_clk, m_ser, m_adc, m_phy}};
      op_tbl[6] = '{K_WR, set_adr(SR_LED), {24'($urandom), m_led}, op_tbl[5].exp};
      op_tbl[7] = '{K_WR, set_adr(SR_LED_SRC), {24'($urandom), m_src}, op_tbl[5].exp};
      for (int i = 0; i < 4; i++) begin
         d = wb_data_t'(i);
         op_tbl[8+i] = '{K_LED, '0, d,
                         {24'b0, expected_leds(m_src, m_led, d[1], d[0])}};
      end
      // Input bits from the LSB up are sim, divider, button, clk_status, link_up, phy_int_n
      d = $urandom;
      op_tbl[12] = '{K_RD, rb_adr(RB_CONFIG), d, {d[0], 27'b0, d[4:1]}};
      d = $urandom;
      op_tbl[13] = '{K_RD, rb_adr(RB_IRQ), d,
                     (32'(d[8]) << 4) | (32'(d[7]) << 10) | (32'(d[6]) << 11) |
                     (32'(d[5]) << 13)};
      op_tbl[14] = '{K_RD, rb_adr(2), $urandom, '0};
      op_tbl[15] = '{K_CYC, rb_adr(RB_CYCLES), 32'(2 + $urandom % 6), '0};
      op_tbl[16] = '{K_ONE, set_adr(SR_SIMTIMER), 32'(3 + $urandom % (MAX_TMR - 2)), '0};
      op_tbl[17] = '{K_PER, set_adr(SR_SIMTIMER + 1), 32'(3 + $urandom % (MAX_TMR - 2)),
                     '0};
      op_tbl[18] = '{K_ERR, 16'h1000, $urandom, '0};
      op_tbl[19] = '{K_ERR, 16'h3400, $urandom, '0};
   endtask

   initial begin
      logic a, e;
      wb_data_t rd, rd2;
      int w, t0, t1, n;
      ctrl_outs_t ctrl_before;
      led_t leds_before;
      void'($urandom(32'hbe3e));
      wb_rst = 1'b1;
      bus_req = '0;
      {sim_mode, button, clk_status, link_up, phy_int_n} = '0;
      clock_divider = '0;
      build_table();
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      wb_rst = 1'b0;

      //////////////////////////////
      // Reset values
      row_fail = 1'b0;
      repeat (5) begin
         @(negedge dsp_clk);
         check_val("ctrl_o", 32'(ctrl), '0);
         check_val("phy_reset_n_o", 32'(phy_reset_n), 32'd1);
         check_val("leds_o", 32'(leds), '0);
         check_true(!onetime_int && !periodic_int, "interrupt high after reset");
      end
      $display("reset test: %s", row_fail ? "failed" : "ok");

      //////////////////////////////
      // Table
      for (int r = 0; r < NROWS; r++) begin
         row_fail = 1'b0;
         case (op_tbl[r].kind)
            K_WR: begin
               bus_access(1'b1, op_tbl[r].addr, op_tbl[r].data, a, e, rd, w);
               check_true(a && !e && w == 1, "write not acked one cycle after stb");
               check_val("ctrl_o", 32'(ctrl), op_tbl[r].exp);
               check_val("phy_reset_n_o", 32'(phy_reset_n),
                         {31'b0, ~op_tbl[r].exp[0]});
            end
            K_LED: begin
               {clk_status, link_up} = op_tbl[r].data[1:0];
               @(negedge dsp_clk);
               check_val("leds_o", 32'(leds), op_tbl[r].exp);
            end
            K_RD: begin
               {phy_int_n, link_up, clk_status, button} = op_tbl[r].data[8:5];
               {clock_divider, sim_mode} = op_tbl[r].data[4:0];
               bus_access(1'b0, op_tbl[r].addr, '0, a, e, rd, w);
               check_true(a && !e && w == 1, "read not acked one cycle after stb");
               check_val("read data", rd, op_tbl[r].exp);
            end
            K_CYC: begin
               bus_access(1'b0, op_tbl[r].addr, '0, a, e, rd, w);
               t0 = ack_cyc;
               repeat (op_tbl[r].data) @(negedge dsp_clk);
               bus_access(1'b0, op_tbl[r].addr, '0, a, e, rd2, w);
               check_val("cycle count delta", rd2 - rd, wb_data_t'(ack_cyc - t0));
            end
            K_ONE: begin
               bus_access(1'b1, op_tbl[r].addr, op_tbl[r].data, a, e, rd, w);
               t0 = ack_cyc;
               while (cyc < t0 + int'(op_tbl[r].data) + 10) @(negedge dsp_clk);
               n = 0;
               foreach (one_q[i]) begin
                  if (one_q[i] > t0) begin
                     n++;
                     check_val("onetime_int delay", 32'(one_q[i] - t0), op_tbl[r].data);
                  end
               end
               check_val("onetime_int pulses", 32'(n), 32'd1);
            end
            K_PER: begin
               bus_access(1'b1, op_tbl[r].addr, op_tbl[r].data, a, e, rd, w);
               t0 = ack_cyc;
               // One cycle past the third pulse so its time stamp is logged
               while (cyc <= t0 + 3 * int'(op_tbl[r].data)) begin
                  @(negedge dsp_clk);
               end
               n = 0;
               foreach (per_q[i]) begin
                  if (per_q[i] > t0) begin
                     n++;
                     check_val("periodic_int time", 32'(per_q[i] - t0),
                               op_tbl[r].data * n);
                  end
               end
               check_val("periodic_int pulses", 32'(n), 32'd3);
               // Period of zero stops it
               bus_access(1'b1, op_tbl[r].addr, '0, a, e, rd, w);
               t1 = ack_cyc;
               while (cyc < t1 + 2 * int'(op_tbl[r].data) + 4) @(negedge dsp_clk);
               n = 0;
               foreach (per_q[i]) begin
                  if (per_q[i] > t1) begin
                     n++;
                  end
               end
               check_true(n == 0, "periodic_int still pulsing after a zero period");
            end
            default: begin
               ctrl_before = ctrl;
               leds_before = leds;
               bus_access(1'b1, op_tbl[r].addr, op_tbl[r].data, a, e, rd, w);
               check_true(e && !a && w == 1, "unmapped access not answered by err");
               check_val("ctrl_o", 32'(ctrl), 32'(ctrl_before));
               check_val("leds_o", 32'(leds), 32'(leds_before));
            end
         endcase
         $display("row %0d kind %0d addr %h: %s", r, op_tbl[r].kind, op_tbl[r].addr,
                  row_fail ? "failed" : "ok");
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- build.f
ctrl_bus_pkg.sv
ctrl_regs_pkg.sv
wb_decoder.sv
settings_bus.sv
setting_bank.sv
simple_timer.sv
readback_mux.sv
ctrl_core.sv
ctrl_core_properties.sv
ctrl_core_tb.sv

//--- Makefile
# Verilator build and run for the control-plane core

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ctrl_core_tb
FILELIST := build.f
OBJ_DIR  := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the output
run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
